/* sim.f */
common/rv_core_pkg.sv
hdl/rv_regfile.sv
hdl/rv_csr_file.sv
hdl/rv_decoder.sv
hdl/rv_alu_exec.sv
hdl/rv_writeback.sv
hdl/rv_core_top.sv
dv/rv_core_checker.sv
dv/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - common/rv_core_pkg.sv
  - hdl/rv_regfile.sv
  - hdl/rv_csr_file.sv
  - hdl/rv_decoder.sv
  - hdl/rv_alu_exec.sv
  - hdl/rv_writeback.sv
  - hdl/rv_core_top.sv
  - target: simulation
    files:
      - dv/rv_core_checker.sv
      - dv/rv_core_tb.sv

/* dv/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb
  import rv_core_pkg::*;
();

  localparam int clock_period = 40;
  localparam int reset_cycles = 4;
  localparam int drive_delay  = 2;
  localparam int wb_latency   = 3;
  localparam int num_tests    = 23;

  localparam logic [6:0] opc_imm    = 7'b0010011;
  localparam logic [6:0] opc_lui    = 7'b0110111;
  localparam logic [6:0] opc_auipc  = 7'b0010111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_system = 7'b1110011;

  logic      clock;
  logic      reset;
  logic      inst_valid;
  word_t     inst;
  logic      inst_ready;
  logic      wb_valid;
  logic      rd_wen;
  reg_addr_t rd_addr;
  word_t     rd_wdata;
  word_t     pc;

  string     test_name [num_tests];
  word_t     test_inst [num_tests];
  logic      exp_wen   [num_tests];
  reg_addr_t exp_rd    [num_tests];
  word_t     exp_data  [num_tests];
  word_t     exp_pc    [num_tests]; // pc after the instruction retires
  int        entry_count;
  int        test_errors;
  int        pass_count;
  int        fail_count;

  rv_core_top #(
    .reset_pc    (32'h0),
    .reset_mtvec (32'h100)
  ) DUT (
    .i_clock      (clock),
    .i_reset      (reset),
    .i_inst_valid (inst_valid),
    .i_inst       (inst),
    .o_inst_ready (inst_ready),
    .o_wb_valid   (wb_valid),
    .o_rd_wen     (rd_wen),
    .o_rd_addr    (rd_addr),
    .o_rd_wdata   (rd_wdata),
    .o_pc         (pc)
  );

  initial begin
    clock = 1'b0;
    forever #(clock_period / 2) clock = ~clock;
  end

  function automatic word_t itype_word(input logic [11:0] imm, input reg_addr_t rs1,
                                       input logic [2:0] funct3, input reg_addr_t rd,
                                       input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  function automatic word_t rtype_word(input logic [6:0] funct7, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input reg_addr_t rd);
    return {funct7, rs2, rs1, 3'b000, rd, 7'b0110011};
  endfunction

  function automatic word_t utype_word(input logic [19:0] imm, input reg_addr_t rd,
                                       input logic [6:0] opcode);
    return {imm, rd, opcode};
  endfunction

  // J and B immediates are scrambled across the word as the ISA lays them out
  function automatic word_t jtype_word(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic word_t btype_word(input logic [12:0] imm, input reg_addr_t rs2,
                                       input reg_addr_t rs1, input logic [2:0] funct3);
    return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic add_entry(input string name, input word_t inst_word, input logic wen,
                           input reg_addr_t rd, input word_t data, input word_t next_pc);
    test_name[entry_count] = name;
    test_inst[entry_count] = inst_word;
    exp_wen[entry_count]   = wen;
    exp_rd[entry_count]    = rd;
    exp_data[entry_count]  = data;
    exp_pc[entry_count]    = next_pc;
    entry_count++;
  endtask

  task automatic fill_table();
    add_entry("addi_pos", itype_word(12'd5, 5'd0, 3'b000, 5'd1, opc_imm),
              1'b1, 5'd1, 32'd5, 32'h04);
    add_entry("addi_neg", itype_word(12'hffd, 5'd0, 3'b000, 5'd2, opc_imm),
              1'b1, 5'd2, 32'hffff_fffd, 32'h08);
    add_entry("add", rtype_word(7'b0000000, 5'd2, 5'd1, 5'd3), 1'b1, 5'd3, 32'd2, 32'h0c);
    add_entry("sub", rtype_word(7'b0100000, 5'd2, 5'd1, 5'd4), 1'b1, 5'd4, 32'd8, 32'h10);
    add_entry("lui", utype_word(20'h12345, 5'd5, opc_lui), 1'b1, 5'd5, 32'h1234_5000, 32'h14);
    add_entry("auipc", utype_word(20'h00001, 5'd6, opc_auipc), 1'b1, 5'd6, 32'h1014, 32'h18);
    // the write request to x0 still shows on the bus, the later add proves it was dropped
    add_entry("addi_x0", itype_word(12'd7, 5'd1, 3'b000, 5'd0, opc_imm),
              1'b1, 5'd0, 32'd12, 32'h1c);
    add_entry("add_from_x0", rtype_word(7'b0000000, 5'd1, 5'd0, 5'd7),
              1'b1, 5'd7, 32'd5, 32'h20);
    add_entry("jal", jtype_word(21'd16, 5'd8), 1'b1, 5'd8, 32'h24, 32'h30);
    add_entry("addi_base", itype_word(12'h041, 5'd0, 3'b000, 5'd9, opc_imm),
              1'b1, 5'd9, 32'h41, 32'h34);
    add_entry("jalr", itype_word(12'h020, 5'd9, 3'b000, 5'd10, opc_jalr),
              1'b1, 5'd10, 32'h38, 32'h60);
    add_entry("beq_taken", btype_word(13'd8, 5'd7, 5'd1, 3'b000), 1'b0, 5'd0, 32'd0, 32'h68);
    add_entry("beq_not_taken", btype_word(13'd8, 5'd2, 5'd1, 3'b000),
              1'b0, 5'd0, 32'd0, 32'h6c);
    add_entry("bne_taken", btype_word(13'd12, 5'd2, 5'd1, 3'b001), 1'b0, 5'd0, 32'd0, 32'h78);
    add_entry("bne_not_taken", btype_word(13'd8, 5'd7, 5'd1, 3'b001),
              1'b0, 5'd0, 32'd0, 32'h7c);
    add_entry("addi_vector", itype_word(12'h200, 5'd0, 3'b000, 5'd11, opc_imm),
              1'b1, 5'd11, 32'h200, 32'h80);
    add_entry("csrrw_mtvec_old", itype_word(csr_mtvec, 5'd11, 3'b001, 5'd12, opc_system),
              1'b1, 5'd12, 32'h100, 32'h84);
    add_entry("csrrw_mtvec_new", itype_word(csr_mtvec, 5'd11, 3'b001, 5'd13, opc_system),
              1'b1, 5'd13, 32'h200, 32'h88);
    add_entry("ecall", itype_word(12'h000, 5'd0, 3'b000, 5'd0, opc_system),
              1'b0, 5'd0, 32'd0, 32'h200);
    // mepc holds the ecall pc and gets the link value of the jalr as return address
    add_entry("csrrw_mepc", itype_word(csr_mepc, 5'd10, 3'b001, 5'd14, opc_system),
              1'b1, 5'd14, 32'h88, 32'h204);
    add_entry("mret", itype_word(12'h302, 5'd0, 3'b000, 5'd0, opc_system),
              1'b0, 5'd0, 32'd0, 32'h38);
    add_entry("csrrw_mcause", itype_word(csr_mcause, 5'd0, 3'b001, 5'd15, opc_system),
              1'b1, 5'd15, 32'd11, 32'h3c);
    add_entry("add_sum", rtype_word(7'b0000000, 5'd15, 5'd14, 5'd16),
              1'b1, 5'd16, 32'h93, 32'h40);
  endtask

  task automatic check_word(input string name, input string field, input word_t expected,
                            input word_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h", name, field, expected,
               actual);
      test_errors++;
    end
  endtask

  task automatic check_reg(input string name, input string field, input reg_addr_t expected,
                           input reg_addr_t actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected x%0d actual x%0d", name, field, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_flag(input string name, input string field, input logic expected,
                            input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s %s expected %b actual %b", name, field, expected, actual);
      test_errors++;
    end
  endtask

  task automatic run_test(input int idx);
    int cycles;
    test_errors = 0;
    // the word is offered while the core is still busy and has to wait for ready
    inst_valid = 1'b1;
    inst       = test_inst[idx];
    while (!inst_ready) begin
      @(posedge clock);
      #drive_delay;
    end
    @(posedge clock); // accepting edge
    #drive_delay;
    inst_valid = 1'b0;
    cycles     = 0;
    while (!wb_valid) begin
      @(posedge clock);
      #drive_delay;
      cycles++;
    end
    if (cycles != wb_latency) begin
      $display("%s retired %0d cycles after acceptance instead of %0d", test_name[idx],
               cycles, wb_latency);
      test_errors++;
    end
    check_flag(test_name[idx], "inst_ready", 1'b0, inst_ready); // still busy at writeback
    check_flag(test_name[idx], "rd_wen", exp_wen[idx], rd_wen);
    if (exp_wen[idx]) begin
      check_reg(test_name[idx], "rd_addr", exp_rd[idx], rd_addr);
      check_word(test_name[idx], "rd_wdata", exp_data[idx], rd_wdata);
    end
    check_word(test_name[idx], "pc", exp_pc[idx], pc);
    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", test_name[idx]);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d errors", test_name[idx], test_errors);
    end
  endtask

  initial begin
    inst_valid  = 1'b0;
    inst        = '0;
    reset       = 1'b1;
    entry_count = 0;
    test_errors = 0;
    pass_count  = 0;
    fail_count  = 0;
    fill_table();
    repeat (reset_cycles) @(posedge clock);
    #drive_delay;
    reset = 1'b0;
    for (int i = 0; i < entry_count; i++) begin
      run_test(i);
    end
    $display("tests %0d passed %0d failed %0d assertion failures %0d", entry_count,
             pass_count, fail_count, DUT.u_checker.assert_failures);
    if (fail_count == 0 && DUT.u_checker.assert_failures == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // each instruction needs about five cycles, eight leaves room
  initial begin
    #((num_tests * 8 + reset_cycles) * clock_period);
    $display("watchdog expired before all %0d tests retired, the core looks hung", num_tests);
    $display("Regression failed");
    $finish;
  end

endmodule

/* dv/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker
  import rv_core_pkg::*;
(
  input logic        i_clock,
  input logic        i_reset,
  input logic        i_inst_valid,
  input logic        i_inst_ready,
  input logic        i_wb_valid,
  input logic        i_rd_wen,
  input core_state_e i_state
);

  logic accept;
  int   assert_failures = 0;

  assign accept = i_inst_valid && i_inst_ready;

  wb_single_cycle: assert property (@(posedge i_clock) disable iff (i_reset)
    i_wb_valid |=> !i_wb_valid)
    else begin
      $error("retire pulse lasted more than one cycle");
      assert_failures++;
    end

  // ready stays low through the writeback cycle and the cycle after it
  ready_low_busy: assert property (@(posedge i_clock) disable iff (i_reset)
    accept |=> !i_inst_ready ##1 !i_inst_ready ##1 !i_inst_ready ##1 !i_inst_ready)
    else begin
      $error("instruction ready rose while an instruction was in flight");
      assert_failures++;
    end

  wen_with_wb: assert property (@(posedge i_clock) disable iff (i_reset)
    i_rd_wen |-> i_wb_valid)
    else begin
      $error("register write without a retire pulse");
      assert_failures++;
    end

  wb_three_after: assert property (@(posedge i_clock) disable iff (i_reset)
    accept |=> !i_wb_valid ##1 !i_wb_valid ##1 !i_wb_valid ##1 i_wb_valid)
    else begin
      $error("retire pulse not seen three cycles after acceptance");
      assert_failures++;
    end

  wb_in_state: assert property (@(posedge i_clock) disable iff (i_reset)
    i_wb_valid |-> i_state == st_writeback)
    else begin
      $error("retire pulse outside the writeback state");
      assert_failures++;
    end

endmodule

bind rv_core_top rv_core_checker u_checker (
  .i_clock      (i_clock),
  .i_reset      (i_reset),
  .i_inst_valid (i_inst_valid),
  .i_inst_ready (o_inst_ready),
  .i_wb_valid   (o_wb_valid),
  .i_rd_wen     (o_rd_wen),
  .i_state      (u_decoder.state_q)
);

/* hdl/rv_core_top.sv */
`timescale 1ns/1ps

module rv_core_top
  import rv_core_pkg::*;
#(
  parameter word_t reset_pc    = 32'h0,
  parameter word_t reset_mtvec = 32'h100
) (
  input  logic      i_clock,
  input  logic      i_reset,
  input  logic      i_inst_valid,
  input  word_t     i_inst,
  output logic      o_inst_ready,
  output logic      o_wb_valid,
  output logic      o_rd_wen,
  output reg_addr_t o_rd_addr,
  output word_t     o_rd_wdata,
  output word_t     o_pc
);

  logic      dec_valid;
  op_class_e dec_op_class;
  alu_op_e   dec_alu_op;
  reg_addr_t dec_rd_addr;
  reg_addr_t dec_rs1_addr;
  reg_addr_t dec_rs2_addr;
  word_t     dec_imm;
  csr_addr_t dec_csr_addr;
  word_t     rs1_data;
  word_t     rs2_data;
  csr_addr_t csr_addr;
  word_t     csr_rdata;
  word_t     mepc;
  word_t     mtvec;
  logic      ex_valid;
  word_t     ex_res;
  word_t     ex_pc_next;
  logic      ex_wen;
  logic      ex_csr_wen;
  word_t     ex_csr_wdata;
  logic      ex_brch;
  logic      ex_jal;
  logic      ex_jalr;
  logic      ex_ecall;
  logic      ex_mret;
  word_t     wb_pc_next;
  word_t     wb_csr_wdata;
  logic      wb_csr_wen;
  csr_addr_t wb_csr_addr;
  logic      wb_pc_update;
  word_t     pc_q;

  // the pc register always holds the pc of the instruction in flight
  always_ff @(posedge i_clock or posedge i_reset) begin
    if (i_reset) begin
      pc_q <= reset_pc;
    end else if (o_wb_valid) begin
      pc_q <= wb_pc_update ? wb_pc_next : pc_q + 32'd4;
    end
  end

  assign o_pc     = o_wb_valid ? wb_pc_next : pc_q; // shows the committed pc on retirement
  assign csr_addr = wb_csr_wen ? wb_csr_addr : dec_csr_addr;

  rv_decoder u_decoder (
    .clock        (i_clock),
    .reset        (i_reset),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .i_wb_done    (o_wb_valid),
    .o_inst_ready (o_inst_ready),
    .o_valid      (dec_valid),
    .o_op_class   (dec_op_class),
    .o_alu_op     (dec_alu_op),
    .o_rd_addr    (dec_rd_addr),
    .o_rs1_addr   (dec_rs1_addr),
    .o_rs2_addr   (dec_rs2_addr),
    .o_imm        (dec_imm),
    .o_csr_addr   (dec_csr_addr)
  );

  rv_regfile u_regfile (
    .clock      (i_clock),
    .reset      (i_reset),
    .i_rs1_addr (dec_rs1_addr),
    .i_rs2_addr (dec_rs2_addr),
    .i_wen      (o_rd_wen),
    .i_rd_addr  (o_rd_addr),
    .i_rd_wdata (o_rd_wdata),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_csr_file #(
    .reset_mtvec (reset_mtvec)
  ) u_csr_file (
    .clock       (i_clock),
    .reset       (i_reset),
    .i_csr_addr  (csr_addr),
    .i_csr_wen   (wb_csr_wen),
    .i_csr_wdata (wb_csr_wdata),
    .i_ecall     (ex_valid && ex_ecall),
    .i_trap_pc   (pc_q),
    .o_csr_rdata (csr_rdata),
    .o_mepc      (mepc),
    .o_mtvec     (mtvec)
  );

  rv_alu_exec u_alu_exec (
    .clock       (i_clock),
    .reset       (i_reset),
    .i_valid     (dec_valid),
    .i_op_class  (dec_op_class),
    .i_alu_op    (dec_alu_op),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .i_imm       (dec_imm),
    .i_pc        (pc_q),
    .i_csr_rdata (csr_rdata),
    .o_valid     (ex_valid),
    .o_res       (ex_res),
    .o_pc_next   (ex_pc_next),
    .o_wen       (ex_wen),
    .o_csr_wen   (ex_csr_wen),
    .o_csr_wdata (ex_csr_wdata),
    .o_brch      (ex_brch),
    .o_jal       (ex_jal),
    .o_jalr      (ex_jalr),
    .o_ecall     (ex_ecall),
    .o_mret      (ex_mret)
  );

  rv_writeback u_writeback (
    .clock         (i_clock),
    .reset         (i_reset),
    .i_pre_valid   (ex_valid),
    .i_wen         (ex_wen),
    .i_rd_addr     (dec_rd_addr),
    .i_csr_addr    (dec_csr_addr),
    .i_csr_wen     (ex_csr_wen),
    .i_csr_wdata   (ex_csr_wdata),
    .i_brch        (ex_brch),
    .i_jal         (ex_jal),
    .i_jalr        (ex_jalr),
    .i_ecall       (ex_ecall),
    .i_mret        (ex_mret),
    .i_pc_next     (ex_pc_next),
    .i_mepc        (mepc),
    .i_mtvec       (mtvec),
    .i_res         (ex_res),
    .o_pc_next     (wb_pc_next),
    .o_rd_wdata    (o_rd_wdata),
    .o_csr_wdata   (wb_csr_wdata),
    .o_wbu_wen     (o_rd_wen),
    .o_wbu_csr_wen (wb_csr_wen),
    .o_rd_addr     (o_rd_addr),
    .o_csr_addr    (wb_csr_addr),
    .o_pc_update   (wb_pc_update),
    .o_wb_valid    (o_wb_valid)
  );

endmodule

/* hdl/rv_writeback.sv */
`timescale 1ns/1ps

module rv_writeback
  import rv_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      i_pre_valid,
  input  logic      i_wen,
  input  reg_addr_t i_rd_addr,
  input  csr_addr_t i_csr_addr,
  input  logic      i_csr_wen,
  input  word_t     i_csr_wdata,
  input  logic      i_brch,
  input  logic      i_jal,
  input  logic      i_jalr,
  input  logic      i_ecall,
  input  logic      i_mret,
  input  word_t     i_pc_next,
  input  word_t     i_mepc,
  input  word_t     i_mtvec,
  input  word_t     i_res,
  output word_t     o_pc_next,
  output word_t     o_rd_wdata,
  output word_t     o_csr_wdata,
  output logic      o_wbu_wen,
  output logic      o_wbu_csr_wen,
  output reg_addr_t o_rd_addr,
  output csr_addr_t o_csr_addr,
  output logic      o_pc_update,
  output logic      o_wb_valid
);

  word_t pc_sel;

  // jumps and taken branches already carry their target in i_pc_next
  assign pc_sel = i_ecall ? i_mtvec :
                  i_mret  ? i_mepc  :
                  i_pc_next;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      o_wb_valid    <= 1'b0;
      o_wbu_wen     <= 1'b0;
      o_wbu_csr_wen <= 1'b0;
      o_pc_update   <= 1'b0;
    end else begin
      o_wb_valid    <= i_pre_valid;
      o_wbu_wen     <= i_pre_valid && i_wen;
      o_wbu_csr_wen <= i_pre_valid && i_csr_wen;
      o_pc_update   <= i_pre_valid && (i_jal || i_jalr || i_brch || i_ecall || i_mret);
    end
  end

  always_ff @(posedge clock) begin
    if (i_pre_valid) begin
      o_pc_next   <= pc_sel;
      o_rd_wdata  <= i_res;
      o_csr_wdata <= i_csr_wdata;
      o_rd_addr   <= i_rd_addr;
      o_csr_addr  <= i_csr_addr;
    end
  end

endmodule

/* hdl/rv_alu_exec.sv */
`timescale 1ns/1ps

module rv_alu_exec
  import rv_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      i_valid,
  input  op_class_e i_op_class,
  input  alu_op_e   i_alu_op,
  input  word_t     i_rs1_data,
  input  word_t     i_rs2_data,
  input  word_t     i_imm,
  input  word_t     i_pc,
  input  word_t     i_csr_rdata,
  output logic      o_valid,
  output word_t     o_res,
  output word_t     o_pc_next,
  output logic      o_wen,
  output logic      o_csr_wen,
  output word_t     o_csr_wdata,
  output logic      o_brch,
  output logic      o_jal,
  output logic      o_jalr,
  output logic      o_ecall,
  output logic      o_mret
);

  word_t op_a;
  word_t op_b;
  word_t alu_res;
  word_t pc_seq;
  word_t res_d;
  word_t pc_next_d;
  logic  use_imm;
  logic  taken;

  assign pc_seq  = i_pc + 32'd4;
  assign use_imm = i_op_class inside {op_alu_imm, op_lui, op_auipc};
  assign op_a    = (i_op_class == op_auipc) ? i_pc : i_rs1_data;
  assign op_b    = use_imm ? i_imm : i_rs2_data;

  always_comb begin
    case (i_alu_op)
      alu_sub:    alu_res = op_a - op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = op_a + op_b;
    endcase
  end

  // alu_sub marks BEQ, alu_pass_b marks BNE
  assign taken = (i_op_class == op_branch) &&
                 ((i_alu_op == alu_sub) ? (i_rs1_data == i_rs2_data)
                                        : (i_rs1_data != i_rs2_data));

  always_comb begin
    case (i_op_class)
      op_jal, op_jalr: res_d = pc_seq; // link value
      op_csrrw:        res_d = i_csr_rdata;
      default:         res_d = alu_res;
    endcase
  end

  always_comb begin
    pc_next_d = pc_seq; // ECALL and MRET targets are picked in writeback
    if (i_op_class == op_jal || taken) begin
      pc_next_d = i_pc + i_imm;
    end else if (i_op_class == op_jalr) begin
      pc_next_d = (i_rs1_data + i_imm) & ~32'd1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (i_valid) begin
      o_res       <= res_d;
      o_pc_next   <= pc_next_d;
      o_wen       <= i_op_class inside {op_alu_imm, op_alu_reg, op_lui, op_auipc,
                                        op_jal, op_jalr, op_csrrw};
      o_csr_wen   <= (i_op_class == op_csrrw);
      o_csr_wdata <= i_rs1_data;
      o_brch      <= taken;
      o_jal       <= (i_op_class == op_jal);
      o_jalr      <= (i_op_class == op_jalr);
      o_ecall     <= (i_op_class == op_ecall);
      o_mret      <= (i_op_class == op_mret);
    end
  end

endmodule

/* hdl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder
  import rv_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  logic      i_inst_valid,
  input  word_t     i_inst,
  input  logic      i_wb_done,
  output logic      o_inst_ready,
  output logic      o_valid,
  output op_class_e o_op_class,
  output alu_op_e   o_alu_op,
  output reg_addr_t o_rd_addr,
  output reg_addr_t o_rs1_addr,
  output reg_addr_t o_rs2_addr,
  output word_t     o_imm,
  output csr_addr_t o_csr_addr
);

  localparam logic [11:0] funct12_ecall = 12'h000;
  localparam logic [11:0] funct12_mret  = 12'h302;

  core_state_e state_q;
  word_t       inst_q;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  word_t       imm_i;
  word_t       imm_u;
  word_t       imm_j;
  word_t       imm_b;
  op_class_e   op_class;
  alu_op_e     alu_op;
  word_t       imm;

  assign o_inst_ready = (state_q == st_idle); // one instruction in flight at a time

  assign opcode = opcode_e'(inst_q[6:0]);
  assign funct3 = inst_q[14:12];
  assign funct7 = inst_q[31:25];

  assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
  assign imm_u = {inst_q[31:12], 12'b0};
  assign imm_j = {{12{inst_q[31]}}, inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
  assign imm_b = {{20{inst_q[31]}}, inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};

  // anything not recognised falls through as op_nop and simply retires
  always_comb begin
    op_class = op_nop;
    alu_op   = alu_add;
    imm      = imm_i;
    case (opcode)
      opc_op_imm: begin
        if (funct3 == 3'b000) begin
          op_class = op_alu_imm;
        end
      end
      opc_op: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
          op_class = op_alu_reg;
        end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
          op_class = op_alu_reg;
          alu_op   = alu_sub;
        end
      end
      opc_lui: begin
        op_class = op_lui;
        alu_op   = alu_pass_b;
        imm      = imm_u;
      end
      opc_auipc: begin
        op_class = op_auipc;
        imm      = imm_u;
      end
      opc_jal: begin
        op_class = op_jal;
        imm      = imm_j;
      end
      opc_jalr: begin
        if (funct3 == 3'b000) begin
          op_class = op_jalr;
        end
      end
      opc_branch: begin
        imm = imm_b;
        // the branch sense rides on the alu op, sub means BEQ and pass_b means BNE
        if (funct3 == 3'b000) begin
          op_class = op_branch;
          alu_op   = alu_sub;
        end else if (funct3 == 3'b001) begin
          op_class = op_branch;
          alu_op   = alu_pass_b;
        end
      end
      opc_system: begin
        if (funct3 == 3'b001 && inst_q[31:20] inside {csr_mepc, csr_mtvec, csr_mcause}) begin
          op_class = op_csrrw;
        end else if (funct3 == 3'b000 && inst_q[31:20] == funct12_ecall) begin
          op_class = op_ecall;
        end else if (funct3 == 3'b000 && inst_q[31:20] == funct12_mret) begin
          op_class = op_mret;
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= st_idle;
      o_valid <= 1'b0;
    end else begin
      o_valid <= (state_q == st_decode); // single cycle strobe toward execute
      case (state_q)
        st_idle: begin
          if (i_inst_valid) begin
            state_q <= st_decode;
          end
        end
        st_decode:    state_q <= st_execute;
        st_execute:   state_q <= st_writeback;
        st_writeback: begin
          if (i_wb_done) begin
            state_q <= st_idle;
          end
        end
        default:      state_q <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (o_inst_ready && i_inst_valid) begin
      inst_q <= i_inst;
    end
    if (state_q == st_decode) begin
      o_op_class <= op_class;
      o_alu_op   <= alu_op;
      o_rd_addr  <= inst_q[11:7];
      o_rs1_addr <= inst_q[19:15];
      o_rs2_addr <= inst_q[24:20];
      o_imm      <= imm;
      o_csr_addr <= inst_q[31:20];
    end
  end

endmodule

/* hdl/rv_csr_file.sv */
`timescale 1ns/1ps

module rv_csr_file
  import rv_core_pkg::*;
#(
  parameter word_t reset_mtvec = 32'h100
) (
  input  logic      clock,
  input  logic      reset,
  input  csr_addr_t i_csr_addr,
  input  logic      i_csr_wen,
  input  word_t     i_csr_wdata,
  input  logic      i_ecall,
  input  word_t     i_trap_pc,
  output word_t     o_csr_rdata,
  output word_t     o_mepc,
  output word_t     o_mtvec
);

  word_t mepc_q;
  word_t mtvec_q;
  word_t mcause_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      mepc_q   <= '0;
      mtvec_q  <= reset_mtvec;
      mcause_q <= '0;
    end else if (i_ecall) begin
      // trap entry saves the pc of the ECALL itself
      mepc_q   <= i_trap_pc;
      mcause_q <= cause_ecall_m;
    end else if (i_csr_wen) begin
      case (i_csr_addr)
        csr_mepc:   mepc_q   <= i_csr_wdata;
        csr_mtvec:  mtvec_q  <= i_csr_wdata;
        csr_mcause: mcause_q <= i_csr_wdata;
        default: begin
        end
      endcase
    end
  end

  // read is combinational so CSRRW sees the value before its own write
  always_comb begin
    case (i_csr_addr)
      csr_mepc:   o_csr_rdata = mepc_q;
      csr_mtvec:  o_csr_rdata = mtvec_q;
      csr_mcause: o_csr_rdata = mcause_q;
      default:    o_csr_rdata = '0;
    endcase
  end

  assign o_mepc  = mepc_q;
  assign o_mtvec = mtvec_q;

endmodule

/* hdl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile
  import rv_core_pkg::*;
(
  input  logic      clock,
  input  logic      reset,
  input  reg_addr_t i_rs1_addr,
  input  reg_addr_t i_rs2_addr,
  input  logic      i_wen,
  input  reg_addr_t i_rd_addr,
  input  word_t     i_rd_wdata,
  output word_t     o_rs1_data,
  output word_t     o_rs2_data
);

  word_t regs [32];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_rd_addr != '0) begin // x0 writes are dropped
      regs[i_rd_addr] <= i_rd_wdata;
    end
  end

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

endmodule

/* common/rv_core_pkg.sv */
package rv_core_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  // major opcode field of the supported RV32I instructions
  typedef enum logic [6:0] {
    opc_op_imm = 7'b0010011,
    opc_op     = 7'b0110011,
    opc_lui    = 7'b0110111,
    opc_auipc  = 7'b0010111,
    opc_jal    = 7'b1101111,
    opc_jalr   = 7'b1100111,
    opc_branch = 7'b1100011,
    opc_system = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    op_alu_imm,
    op_alu_reg,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_branch,
    op_csrrw,
    op_ecall,
    op_mret,
    op_nop
  } op_class_e;

  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_pass_b
  } alu_op_e;

  typedef enum logic [1:0] {
    st_idle,
    st_decode,
    st_execute,
    st_writeback
  } core_state_e;

  localparam csr_addr_t csr_mtvec  = 12'h305;
  localparam csr_addr_t csr_mepc   = 12'h341;
  localparam csr_addr_t csr_mcause = 12'h342;

  localparam word_t cause_ecall_m = 32'd11; // environment call from M-mode

endpackage
